//--- Makefile
# Verilator lint and simulation of the board register block

TOP := board_ctrl_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/board_ctrl_sva.sv
// ------------------------------
// axi and safety assertions, bound into board_ctrl_top
// wdog_timeout is the internal guard output
// ------------------------------
`timescale 1ns/1ps

module board_ctrl_sva (
    input logic        sysclk,
    input logic        reset,
    input logic        awvalid,
    input logic        awready,
    input logic        wvalid,
    input logic        wready,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        pwr_enable,
    input logic [3:0]  amp_disable,
    input logic        wdog_timeout
);

    // response valids hold until taken
    a_b_hold: assert property (@(posedge sysclk) disable iff (!reset)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped");
    a_r_hold: assert property (@(posedge sysclk) disable iff (!reset)
        rvalid && !rready |=> rvalid && $stable(rdata)) else $error("rvalid or rdata moved");

    // response only after an accepted write
    a_b_cause: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
        else $error("bvalid without write");

    // safety
    a_pwr_off: assert property (@(posedge sysclk) disable iff (!reset)
        !pwr_enable |-> amp_disable == 4'hf) else $error("amp on without power");
    a_wdog: assert property (@(posedge sysclk) disable iff (!reset)
        wdog_timeout |=> amp_disable == 4'hf) else $error("amp on after timeout");

endmodule

bind board_ctrl_top board_ctrl_sva u_board_ctrl_sva (.*);

//--- bench/board_ctrl_tb.sv
// ------------------------------
// random axi traffic against a register model
// inputs driven on the falling edge, seed fixed
// ------------------------------
`timescale 1ns/1ps
`include "board_macros.svh"

module board_ctrl_tb;

    logic sysclk, reset;
    logic [5:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic [3:0] board_id, safety_amp_disable, amp_disable;
    logic [15:0] temp_sense;
    board_pkg::dig_in_t dig_in;
    board_pkg::stat_in_t stat_in;
    logic pwr_enable, relay_on;

    // model state
    logic m_pwr, m_relay, m_wd;
    logic [3:0] m_dis;
    logic [15:0] m_period;
    logic [31:0] m_debug;
    logic [31:0] seed = 32'd34995;
    int cycles = 0;

    clk_gen u_clk_gen (.sysclk, .reset);

    board_ctrl_top u_board_ctrl_top (.*);

    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= 40000) begin
            $display("timeout: run went past 40000 cycles");
            $display("RESULT: FAIL");
            $fatal(1, "cycle limit");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // expected read word from the register map
    function automatic logic [31:0] expect_read(input logic [3:0] idx);
        case (idx)
            4'd0: return {4'd4, board_id, m_wd, 3'd0,
                          stat_in.mv_good, m_pwr, !stat_in.relay, m_relay,
                          !stat_in.mv_faultn, 3'd0, stat_in.amp_fault,
                          safety_amp_disable, ~m_dis};
            4'd1: return {16'd0, m_period};
            4'd2: return `BOARD_VERSION;
            4'd3: return {dig_in.v_fault, 3'd0, dig_in.enc_a, dig_in.enc_b, dig_in.enc_i,
                          4'd0, dig_in.neg_limit, dig_in.pos_limit, dig_in.home};
            4'd4: return {16'd0, temp_sense};
            4'd5: return m_debug;
            default: return 32'd0;
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge sysclk);
    endtask

    task automatic axi_write(input logic [3:0] idx, input logic [31:0] data);
        logic done;
        @(negedge sysclk);
        awaddr  = {idx, 2'b00};
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        done    = 1'b0;
        while (!done) begin
            #1 done = awready && wready;    // handshake at the coming edge
            @(negedge sysclk);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        done    = 1'b0;
        while (!done) begin
            bready = next_rand() % 4 != 0;  // random stall
            #1 done = bvalid && bready;
            if (done)
                check("bresp", 2'b00, bresp);
            @(negedge sysclk);
        end
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] idx, output logic [31:0] data);
        logic done;
        @(negedge sysclk);
        araddr  = {idx, 2'b00};
        arvalid = 1'b1;
        done    = 1'b0;
        while (!done) begin
            #1 done = arready;
            @(negedge sysclk);
        end
        arvalid = 1'b0;
        done    = 1'b0;
        while (!done) begin
            rready = next_rand() % 4 != 0;
            #1 done = rvalid && rready;
            if (done) begin
                check("rresp", 2'b00, rresp);
                data = rdata;
            end
            @(negedge sysclk);
        end
        rready = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [3:0] idx);
        logic [31:0] got;
        axi_read(idx, got);
        check(name, expect_read(idx), got);
    endtask

    // status write through the mask/value rules
    task automatic status_write(input logic [31:0] w);
        for (int i = 0; i < 4; i++)
            m_dis[i] = !m_pwr || (w[8+i] ? !w[i] : m_dis[i]);   // old power
        if (w[17]) m_relay = w[16];
        if (w[19]) m_pwr = w[18];
        if (w[19] && w[18] || |(w[11:8] & w[3:0]))
            m_wd = 1'b0;
        axi_write(4'd0, w);
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0] safe;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        board_id = 4'h9;
        temp_sense = 16'h1234;
        dig_in = '0;
        stat_in = '{amp_fault: 4'hf, relay: 1'b0, mv_faultn: 1'b1, mv_good: 1'b1};
        safety_amp_disable = 4'd0;
        m_pwr    = 1'b0;
        m_relay  = 1'b0;
        m_wd     = 1'b0;
        m_dis    = 4'hf;
        m_period = 16'd0;
        m_debug = `DEBUG_RESET;
        @(posedge reset);
        wait_cycles(4);

        // ------------------------------
        // 1 reset values
        check("rst amp_disable", 4'hf, amp_disable);
        check("rst pwr_enable", 0, pwr_enable);
        check("rst relay_on", 0, relay_on);
        read_check("rst status", 4'd0);
        read_check("rst timeout", 4'd1);
        read_check("rst version", 4'd2);
        read_check("rst debug", 4'd5);
        read_check("rst unmapped", 4'd7);

        // ------------------------------
        // 2 random reads and writes
        for (int n = 0; n < 150; n++) begin
            r = next_rand();
            if (r[1:0] == 2'd0) begin
                m_debug = next_rand();
                axi_write(4'd5, m_debug);
            end else if (r[1:0] == 2'd1) begin
                r = next_rand();
                m_period = r[15:0] | 16'h0100;   // long period, never fires here
                axi_write(4'd1, {16'd0, m_period});
            end else begin
                read_check("random read", 4'(r[4:2] + r[5]));
            end
        end
        m_period = 0;
        axi_write(4'd1, 32'd0);

        // ------------------------------
        // 3 masked status writes
        wait_cycles(32 * 256);          // mv settle over, amps follow the register
        for (int n = 0; n < 60; n++) begin
            r = next_rand() & 32'h000f_0f0f;
            if (r[19] && !r[18])
                r[11:0] = 12'hf00;      // power off also turns all amps off
            status_write(r);
            check("pwr_enable", m_pwr, pwr_enable);
            check("relay_on", m_relay, relay_on);
            check("amp_disable", m_dis, amp_disable);
            read_check("status", 4'd0);
        end

        // ------------------------------
        // 4 input read-back
        for (int n = 0; n < 20; n++) begin
            @(negedge sysclk);
            r = next_rand();
            dig_in = r[24:0];
            r = next_rand();
            stat_in = r[6:0];
            r = next_rand();
            board_id = r[3:0];
            temp_sense = r[31:16];
            wait_cycles(3);             // two sync stages plus margin
            read_check("digin", 4'd3);
            read_check("tempsns", 4'd4);
            read_check("status inputs", 4'd0);
        end
        stat_in.mv_good = 1'b1;

        // ------------------------------
        // 5 watchdog
        wait_cycles(32 * 256);          // settle again after random mv_good
        m_period = 16'd10;
        axi_write(4'd1, 32'd10);
        status_write(32'h000c_0000);
        status_write(32'h0000_0f0f);
        check("wdog amps on", m_dis, amp_disable);
        wait_cycles(12 * 256);
        m_wd = 1'b1;
        m_dis = 4'hf;
        read_check("wdog status", 4'd0);
        check("wdog amp_disable", 4'hf, amp_disable);
        status_write(32'h000c_0000);
        read_check("wdog cleared", 4'd0);
        m_period = 0;
        axi_write(4'd1, 32'd0);

        // ------------------------------
        // 6 motor voltage and safety
        @(negedge sysclk);
        stat_in.mv_good = 1'b0;
        wait_cycles(4);
        status_write(32'h0000_0f0f);
        @(negedge sysclk);
        stat_in.mv_good = 1'b1;
        for (int c = 0; c < 30 * 256; c++) begin
            @(negedge sysclk);
            check("mv hold", 4'hf, amp_disable);
        end
        wait_cycles(2 * 256);
        check("mv settled", m_dis, amp_disable);
        safe = 4'b0001 << next_rand() % 4;
        @(negedge sysclk);
        safety_amp_disable = safe;
        m_dis = m_dis | safe;
        wait_cycles(3);
        check("safety amp_disable", m_dis, amp_disable);
        read_check("safety status", 4'd0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- bench/clk_gen.sv
// ------------------------------
// sysclk at 4 ns, reset low for the first 10 cycles
// ------------------------------
`timescale 1ns/1ps

module clk_gen (
    output logic sysclk,
    output logic reset      // sync, active low
);

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    initial begin
        reset = 1'b0;
        repeat (10) @(posedge sysclk);
        @(negedge sysclk) reset = 1'b1;     // released away from the active edge
    end

endmodule

//--- hw/axil_reg_port.sv
// ------------------------------
// axi4-lite slave, single outstanding write and read
// wstrb ignored, all writes are full words
// responses always OKAY, address bits 1..0 not decoded
// ------------------------------
`timescale 1ns/1ps

module axil_reg_port (
    input  logic                sysclk,
    input  logic                reset,      // sync, active low
    // write address and data
    input  logic [5:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    // write response
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    // read address and data
    input  logic [5:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    // register side
    output logic                reg_wen,
    output board_pkg::reg_idx_t reg_waddr,
    output logic [31:0]         reg_wdata,
    output board_pkg::reg_idx_t reg_raddr,
    input  logic [31:0]         reg_rdata
);

    logic wr_accept;    // aw and w taken together
    logic rd_accept;    // ar taken

    // ------------------------------
    // handshakes
    // ------------------------------
    assign wr_accept = awvalid && wvalid && !bvalid;   // no new write while resp pending
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;
    assign reg_raddr = araddr[5:2];     // regs form rdata in the same cycle

    assign bresp = 2'b00;   // OKAY
    assign rresp = 2'b00;   // OKAY

    // ------------------------------
    // write strobe and response
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_wen <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            reg_wen <= wr_accept;       // one cycle per accepted write
            if (wr_accept)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;         // held until bready
        end
    end

    // write payload, valid while reg_wen is high
    always_ff @(posedge sysclk) begin
        if (wr_accept) begin
            reg_waddr <= awaddr[5:2];
            reg_wdata <= wdata;
        end
    end

    // ------------------------------
    // read response
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset)
            rvalid <= 1'b0;
        else if (rd_accept)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;             // held until rready
    end

    always_ff @(posedge sysclk) begin
        if (rd_accept)
            rdata <= reg_rdata;         // captured at the ar handshake
    end

endmodule

//--- hw/board_ctrl_top.sv
// ------------------------------
// board register block top, axi4-lite host side
// inputs arrive async and are synced here
// ------------------------------
`timescale 1ns/1ps

module board_ctrl_top (
    input  logic                sysclk,
    input  logic                reset,
    input  logic [5:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [5:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic [3:0]          board_id,
    input  logic [15:0]         temp_sense,
    input  board_pkg::dig_in_t  dig_in,
    input  board_pkg::stat_in_t stat_in,
    input  logic [3:0]          safety_amp_disable,
    output logic [3:0]          amp_disable,
    output logic                pwr_enable,
    output logic                relay_on
);

    logic                reg_wen;
    board_pkg::reg_idx_t reg_waddr;
    board_pkg::reg_idx_t reg_raddr;
    logic [31:0]         reg_wdata;
    logic [31:0]         reg_rdata;
    board_pkg::dig_in_t  dig_sync;
    board_pkg::stat_in_t stat_sync;
    logic                wdog_kick;
    logic                powerup_cmd;
    logic [15:0]         wdog_period;
    logic                wdog_timeout;
    logic                mv_hold;

    axil_reg_port u_axil_reg_port (
        .sysclk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .reg_wen, .reg_waddr, .reg_wdata, .reg_raddr, .reg_rdata
    );

    // board pins into sysclk
    input_sync #(.payload_t(board_pkg::dig_in_t)) u_dig_sync (
        .sysclk, .reset, .async_in(dig_in), .sync_out(dig_sync)
    );

    input_sync #(.payload_t(board_pkg::stat_in_t)) u_stat_sync (
        .sysclk, .reset, .async_in(stat_in), .sync_out(stat_sync)
    );

    board_regs u_board_regs (
        .sysclk, .reset,
        .reg_wen, .reg_waddr, .reg_wdata, .reg_raddr, .reg_rdata,
        .board_id, .temp_sense, .dig_sync, .stat_sync, .safety_amp_disable,
        .wdog_timeout, .mv_hold,
        .amp_disable, .pwr_enable, .relay_on,
        .wdog_kick, .powerup_cmd, .wdog_period
    );

    power_guard u_power_guard (
        .sysclk, .reset,
        .wdog_kick, .powerup_cmd, .wdog_period,
        .mv_good(stat_sync.mv_good),    // synced copy
        .wdog_timeout, .mv_hold
    );

endmodule

//--- hw/board_macros.svh
// ------------------------------
// register map and timing constants for the board block
// indices come from address bits 5..2, unmapped ones read zero
// MV_DELAY_TICKS is cut down for short simulation runs
// ------------------------------
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// register word indices
`define REG_STATUS   4'd0
`define REG_TIMEOUT  4'd1
`define REG_VERSION  4'd2
`define REG_DIGIN    4'd3
`define REG_TEMPSNS  4'd4
`define REG_DEBUG    4'd5

`define BOARD_VERSION  32'h4D433034   // ascii "MC04"
`define DEBUG_RESET    32'h00002000
`define WDOG_TICK_BITS 8              // tick every 256 sysclk
`define MV_DELAY_TICKS 16'd30         // hold-off after mv_good, in ticks

`endif

//--- hw/board_pkg.sv
// ------------------------------
// shared types for the board register block
// input bundles are raw pin groups, no polarity fixing here
// ------------------------------
package board_pkg;

    // register word index, taken from address bits 5..2
    typedef logic [3:0] reg_idx_t;

    // digital inputs, one bit per axis in each 4-bit field
    typedef struct packed {
        logic [3:0] enc_a;      // encoder a
        logic [3:0] enc_b;      // encoder b
        logic [3:0] enc_i;      // encoder index
        logic [3:0] neg_limit;  // negative limit switch
        logic [3:0] pos_limit;  // positive limit switch
        logic [3:0] home;       // home switch
        logic       v_fault;    // encoder supply fault
    } dig_in_t;                 // 25 bits

    // status inputs from the power stage
    typedef struct packed {
        logic [3:0] amp_fault;  // 1 = amp ok, 0 = fault
        logic       relay;      // safety relay contact
        logic       mv_faultn;  // motor supply fault, active low
        logic       mv_good;    // motor voltage good
    } stat_in_t;                // 7 bits

endpackage

//--- hw/board_regs.sv
// ------------------------------
// board register file, mask/value writes on status
// amp enables need pwr_enable set before the write
// disable state is sticky on watchdog and safety input
// ------------------------------
`timescale 1ns/1ps
`include "board_macros.svh"

module board_regs (
    input  logic                 sysclk,
    input  logic                 reset,
    input  logic                 reg_wen,
    input  board_pkg::reg_idx_t  reg_waddr,
    input  logic [31:0]          reg_wdata,
    input  board_pkg::reg_idx_t  reg_raddr,
    output logic [31:0]          reg_rdata,
    input  logic [3:0]           board_id,
    input  logic [15:0]          temp_sense,
    input  board_pkg::dig_in_t   dig_sync,
    input  board_pkg::stat_in_t  stat_sync,
    input  logic [3:0]           safety_amp_disable,
    input  logic                 wdog_timeout,
    input  logic                 mv_hold,
    output logic [3:0]           amp_disable,
    output logic                 pwr_enable,
    output logic                 relay_on,
    output logic                 wdog_kick,
    output logic                 powerup_cmd,
    output logic [15:0]          wdog_period
);

    logic [3:0]  reg_disable;   // 1 = axis disabled
    logic [31:0] reg_debug;     // scratch, host owned
    logic        write_status;
    logic [3:0]  amp_enable_cmd;

    // ------------------------------
    // command decode
    // ------------------------------
    assign write_status   = reg_wen && (reg_waddr == `REG_STATUS);
    assign amp_enable_cmd = reg_wdata[11:8] & reg_wdata[3:0];   // mask and value both set
    assign powerup_cmd    = write_status &&
                            ((reg_wdata[19] && reg_wdata[18]) || (|amp_enable_cmd));
    assign wdog_kick      = reg_wen;                  // any write restarts the watchdog

    assign amp_disable = reg_disable | {4{mv_hold}};  // held off during mv settle

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_disable <= 4'hf;          // all axes off
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            wdog_period <= 16'd0;         // watchdog off
            reg_debug   <= `DEBUG_RESET;
        end else if (reg_wen) begin
            case (reg_waddr)
                `REG_STATUS: begin
                    // old pwr_enable gates the amp enables
                    for (int i = 0; i < 4; i++)
                        reg_disable[i] <= !pwr_enable ||
                            (reg_wdata[8+i] ? !reg_wdata[i] : reg_disable[i]);
                    relay_on   <= reg_wdata[17] ? reg_wdata[16] : relay_on;
                    pwr_enable <= reg_wdata[19] ? reg_wdata[18] : pwr_enable;
                end
                `REG_TIMEOUT: wdog_period <= reg_wdata[15:0];
                `REG_DEBUG:   reg_debug   <= reg_wdata;
                default: ;                // read-only or unmapped
            endcase
        end else begin
            // no write this cycle, force axes off
            reg_disable <= reg_disable | (wdog_timeout ? 4'hf : safety_amp_disable);
        end
    end

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        case (reg_raddr)
            `REG_STATUS:  reg_rdata = {4'd4, board_id,
                                       wdog_timeout, 3'd0,
                                       stat_sync.mv_good, pwr_enable, !stat_sync.relay, relay_on,
                                       !stat_sync.mv_faultn, 3'd0,
                                       stat_sync.amp_fault,
                                       safety_amp_disable, ~reg_disable};
            `REG_TIMEOUT: reg_rdata = {16'd0, wdog_period};
            `REG_VERSION: reg_rdata = `BOARD_VERSION;
            `REG_DIGIN:   reg_rdata = {dig_sync.v_fault, 3'd0,
                                       dig_sync.enc_a, dig_sync.enc_b, dig_sync.enc_i,
                                       4'd0,      // no digital outputs on this board
                                       dig_sync.neg_limit, dig_sync.pos_limit, dig_sync.home};
            `REG_TEMPSNS: reg_rdata = {16'd0, temp_sense};
            `REG_DEBUG:   reg_rdata = reg_debug;
            default:      reg_rdata = 32'd0;
        endcase
    end

endmodule

//--- hw/input_sync.sv
// ------------------------------
// two-flop synchronizer for async board pins
// no glitch filter, adds two sysclk of latency
// fields of a struct are not sampled coherently
// ------------------------------
`timescale 1ns/1ps

module input_sync #(
    parameter type payload_t = logic
) (
    input  logic     sysclk,
    input  logic     reset,     // sync, active low
    input  payload_t async_in,
    output payload_t sync_out
);

    payload_t meta_q;   // first stage, may go metastable

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            meta_q   <= '0;
            sync_out <= '0;
        end else begin
            meta_q   <= async_in;
            sync_out <= meta_q;
        end
    end

endmodule

//--- hw/power_guard.sv
// ------------------------------
// watchdog and motor-voltage settle timers
// both count on a tick of 2^WDOG_TICK_BITS sysclk
// timeout clears only on powerup_cmd or reset
// ------------------------------
`timescale 1ns/1ps
`include "board_macros.svh"

module power_guard (
    input  logic        sysclk,
    input  logic        reset,
    input  logic        wdog_kick,      // any register write
    input  logic        powerup_cmd,    // host turning power or amps on
    input  logic [15:0] wdog_period,    // in ticks, 0 = off
    input  logic        mv_good,
    output logic        wdog_timeout,
    output logic        mv_hold
);

    logic [`WDOG_TICK_BITS-1:0] tick_cnt;
    logic                       tick;
    logic [15:0]                wdog_count;     // ticks since last kick
    logic [15:0]                mv_count;       // ticks since mv_good rose
    logic                       settle_hold;

    // ------------------------------
    // tick divider
    // ------------------------------
    assign tick = &tick_cnt;    // one cycle every 2^n

    always_ff @(posedge sysclk) begin
        if (!reset)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    // ------------------------------
    // watchdog
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset || powerup_cmd) begin
            wdog_count   <= 16'd0;
            wdog_timeout <= 1'b0;
        end else if (wdog_kick) begin
            wdog_count   <= 16'd0;                      // restart, flag stays
        end else if (tick && (wdog_period != 16'd0)) begin
            if (wdog_count < wdog_period)
                wdog_count <= wdog_count + 1'b1;
            else
                wdog_timeout <= 1'b1;                   // latched
        end
    end

    // ------------------------------
    // motor voltage settle
    // ------------------------------
    assign mv_hold = !mv_good || settle_hold;   // no wait for a tick on drop

    always_ff @(posedge sysclk) begin
        if (!reset || !mv_good) begin
            mv_count    <= 16'd0;
            settle_hold <= 1'b1;
        end else if (tick) begin
            if (mv_count < `MV_DELAY_TICKS)
                mv_count <= mv_count + 1'b1;            // still settling
            else
                settle_hold <= 1'b0;
        end
    end

endmodule

//--- list.f
+incdir+hw
hw/board_pkg.sv
hw/axil_reg_port.sv
hw/input_sync.sv
hw/board_regs.sv
hw/power_guard.sv
hw/board_ctrl_top.sv
bench/clk_gen.sv
bench/board_ctrl_sva.sv
bench/board_ctrl_tb.sv
